// File: hw/fpgaRamPkg.sv
// ------------------------------------------------------------
// FPGA storage package
// Address map, bank codes, address views and the bus request
// ------------------------------------------------------------
package fpgaRamPkg;

    parameter int AddrWidth = 12;           // Word address bits
    parameter int DataWidth = 32;           // Bus data bits

    // Bank codes, top two address bits
    typedef enum logic [1:0] {
        BankRam1 = 2'd0,                    // 512x16
        BankRam2 = 2'd1,                    // 1024x8
        BankRam3 = 2'd2,                    // 512x32
        BankRegs = 2'd3                     // Register bank
    } bank_e;

    // RAM view of the word address
    typedef struct packed {
        bank_e       bank;
        logic [9:0]  offset;                // RAMs use the low bits
    } ramAddr_t;

    // Register view of the word address
    typedef struct packed {
        bank_e       bank;
        logic [7:0]  spare;                 // Ignored
        logic [1:0]  regIdx;
    } regAddr_t;

    // Same address word, decoded two ways
    typedef union packed {
        ramAddr_t ramView;
        regAddr_t regView;
    } wbAddr_u;

    // Request fields held by the host until ACK
    typedef struct packed {
        wbAddr_u              adr;
        logic [DataWidth-1:0] dat;
        logic [3:0]           byteStb;
        logic                 we;
    } wbReq_t;

    // Register indexes, index 3 unmapped
    localparam logic [1:0] RegIdIdx      = 2'd0;
    localparam logic [1:0] RegScratchIdx = 2'd1;
    localparam logic [1:0] RegWrCntIdx   = 2'd2;

endpackage

// File: hw/syncRam.sv
// ------------------------------------------------------------
// Inferred single-clock RAM
// Byte lane writes, registered read port
// ------------------------------------------------------------
module syncRam #(
    parameter int Depth     = 512,
    parameter int Width     = 32,
    parameter int ByteLanes = 4
) (
    input  logic                       WBs_CLK_i,
    input  logic [ByteLanes-1:0]       wrEn_i,     // One enable per lane
    input  logic [$clog2(Depth)-1:0]   addr_i,
    input  logic [Width-1:0]           wrDat_i,
    output logic [Width-1:0]           rdDat_o     // Valid one cycle after addr_i
);

    localparam int LaneWidth = Width / ByteLanes;

    // Storage array, no reset as in block RAM
    logic [Width-1:0] memArray [Depth];

    //------------------------------------------------------------
    // Write and read on the same edge
    //------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i)
    begin
        for (int lane = 0; lane < ByteLanes; lane++)
        begin
            if (wrEn_i[lane])
            begin
                memArray[addr_i][lane*LaneWidth +: LaneWidth] <=
                    wrDat_i[lane*LaneWidth +: LaneWidth];
            end
        end
        rdDat_o <= memArray[addr_i];   // Old data on simultaneous write
    end

    // Any enabled lane must target a real row
    addrInRange: assert property (
        @(posedge WBs_CLK_i) (|wrEn_i) |-> (int'(addr_i) < Depth)
    ) else $error("syncRam write beyond depth at %0t", $time);

endmodule

// File: hw/fpgaRams.sv
// ------------------------------------------------------------
// FPGA RAM block
// Three RAMs, write decode and one-cycle acknowledge
// ------------------------------------------------------------
module fpgaRams import fpgaRamPkg::*; (
    input  logic                 WBs_CLK_i,
    input  logic                 WBs_RST_i,
    input  wbReq_t               req_i,
    input  logic                 WBs_STB_i,
    input  logic                 ram1Cyc_i,
    input  logic                 ram2Cyc_i,
    input  logic                 ram3Cyc_i,
    output logic [DataWidth-1:0] ram1Dat_o,   // 16 bits, zero-extended
    output logic [DataWidth-1:0] ram2Dat_o,   // 8 bits, zero-extended
    output logic [DataWidth-1:0] ram3Dat_o,
    output logic                 ramAck_o,
    output logic                 ramWrDone_o  // Pulse per accepted write
);

    logic        ram1WrDcd;
    logic        ram2WrDcd;
    logic        ram3WrDcd;
    logic        ramAckNxt;
    logic [15:0] ram1Rd;
    logic [7:0]  ram2Rd;
    logic [31:0] ram3Rd;

    //------------------------------------------------------------
    // Write decode and acknowledge
    //------------------------------------------------------------
    // One write per access, blocked in the ACK cycle
    assign ram1WrDcd = ram1Cyc_i & WBs_STB_i & req_i.we & ~ramAck_o;
    assign ram2WrDcd = ram2Cyc_i & WBs_STB_i & req_i.we & ~ramAck_o;
    assign ram3WrDcd = ram3Cyc_i & WBs_STB_i & req_i.we & ~ramAck_o;

    assign ramAckNxt = (ram1Cyc_i | ram2Cyc_i | ram3Cyc_i) & WBs_STB_i & ~ramAck_o;

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            ramAck_o    <= 1'b0;
            ramWrDone_o <= 1'b0;
        end
        else
        begin
            ramAck_o    <= ramAckNxt;
            ramWrDone_o <= ram1WrDcd | ram2WrDcd | ram3WrDcd; // Lands in ACK cycle
        end
    end

    //------------------------------------------------------------
    // RAM instances
    //------------------------------------------------------------
    syncRam #(.Depth(512), .Width(16), .ByteLanes(2)) ram1 (
        .WBs_CLK_i (WBs_CLK_i),
        .wrEn_i    ({2{ram1WrDcd}} & req_i.byteStb[1:0]),
        .addr_i    (req_i.adr.ramView.offset[8:0]),   // Wraps at 512
        .wrDat_i   (req_i.dat[15:0]),
        .rdDat_o   (ram1Rd)
    );

    syncRam #(.Depth(1024), .Width(8), .ByteLanes(1)) ram2 (
        .WBs_CLK_i (WBs_CLK_i),
        .wrEn_i    (ram2WrDcd & req_i.byteStb[0]),     // Lane 0 only
        .addr_i    (req_i.adr.ramView.offset),
        .wrDat_i   (req_i.dat[7:0]),
        .rdDat_o   (ram2Rd)
    );

    syncRam #(.Depth(512), .Width(32), .ByteLanes(4)) ram3 (
        .WBs_CLK_i (WBs_CLK_i),
        .wrEn_i    ({4{ram3WrDcd}} & req_i.byteStb),
        .addr_i    (req_i.adr.ramView.offset[8:0]),
        .wrDat_i   (req_i.dat),
        .rdDat_o   (ram3Rd)
    );

    // Narrow words padded with zeros
    assign ram1Dat_o = {{(DataWidth-16){1'b0}}, ram1Rd};
    assign ram2Dat_o = {{(DataWidth-8){1'b0}}, ram2Rd};
    assign ram3Dat_o = ram3Rd;

    //------------------------------------------------------------
    // Checks
    //------------------------------------------------------------
    ackSinglePulse: assert property (
        @(posedge WBs_CLK_i) disable iff (WBs_RST_i) ramAck_o |=> !ramAck_o
    ) else $error("RAM ACK held two cycles at %0t", $time);

    ramSelOneHot: assert property (
        @(posedge WBs_CLK_i) disable iff (WBs_RST_i)
            $onehot0({ram1Cyc_i, ram2Cyc_i, ram3Cyc_i})
    ) else $error("Several RAM selects high at %0t", $time);

endmodule

// File: hw/fpgaRegs.sv
// ------------------------------------------------------------
// FPGA register bank
// Identity, scratch, RAM write counter and default word
// ------------------------------------------------------------
module fpgaRegs import fpgaRamPkg::*; #(
    parameter logic [31:0] IdValue     = 32'h0F9A_0001,
    parameter logic [31:0] DefRegValue = 32'hFABD_EFAC
) (
    input  logic                 WBs_CLK_i,
    input  logic                 WBs_RST_i,
    input  wbReq_t               req_i,
    input  logic                 WBs_STB_i,
    input  logic                 regCyc_i,
    input  logic                 ramWrDone_i,
    output logic [DataWidth-1:0] regDat_o,
    output logic                 regAck_o
);

    logic [1:0]           regIdx;
    logic                 regAckNxt;
    logic                 scratchWrDcd;
    logic [DataWidth-1:0] scratchReg;
    logic [31:0]          wrCnt;          // Wraps silently
    logic [DataWidth-1:0] rdNxt;

    assign regIdx    = req_i.adr.regView.regIdx;   // Register view of address
    assign regAckNxt = regCyc_i & WBs_STB_i & ~regAck_o;

    // Only the scratch word is writable
    assign scratchWrDcd = regAckNxt & req_i.we & (regIdx == RegScratchIdx);

    //------------------------------------------------------------
    // Control state and writable registers
    //------------------------------------------------------------
    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
        begin
            regAck_o   <= 1'b0;
            scratchReg <= '0;
            wrCnt      <= '0;
        end
        else
        begin
            regAck_o <= regAckNxt;
            if (scratchWrDcd)
            begin
                for (int lane = 0; lane < 4; lane++)
                begin
                    if (req_i.byteStb[lane])
                    begin
                        scratchReg[lane*8 +: 8] <= req_i.dat[lane*8 +: 8];
                    end
                end
            end
            if (ramWrDone_i)
                wrCnt <= wrCnt + 32'd1;      // One per RAM write
        end
    end

    // Read select by index
    always_comb
    begin
        case (regIdx)
            RegIdIdx:      rdNxt = IdValue;
            RegScratchIdx: rdNxt = scratchReg;
            RegWrCntIdx:   rdNxt = wrCnt;
            default:       rdNxt = DefRegValue;   // Unmapped index
        endcase
    end

    // Read word captured on the access edge
    always_ff @(posedge WBs_CLK_i)
    begin
        if (regAckNxt)
            regDat_o <= rdNxt;
    end

endmodule

// File: hw/wbBusDecode.sv
// ------------------------------------------------------------
// Wishbone bank decoder
// Bank selects, read steering and merged acknowledge
// ------------------------------------------------------------
module wbBusDecode import fpgaRamPkg::*; (
    input  logic                 WBs_CLK_i,
    input  logic                 WBs_RST_i,
    input  wbReq_t               req_i,
    input  logic                 WBs_CYC_i,
    input  logic                 WBs_STB_i,
    output logic                 ram1Cyc_o,
    output logic                 ram2Cyc_o,
    output logic                 ram3Cyc_o,
    output logic                 regCyc_o,
    input  logic [DataWidth-1:0] ram1Dat_i,
    input  logic [DataWidth-1:0] ram2Dat_i,
    input  logic [DataWidth-1:0] ram3Dat_i,
    input  logic [DataWidth-1:0] regDat_i,
    input  logic                 ramAck_i,
    input  logic                 regAck_i,
    output logic [DataWidth-1:0] WBs_DAT_o,
    output logic                 WBs_ACK_o
);

    bank_e reqBank;
    bank_e lastBank;      // Bank of access in flight
    logic  accStart;

    // Bank field sits at the same place in both views
    assign reqBank = req_i.adr.ramView.bank;

    //------------------------------------------------------------
    // Cycle selects
    //------------------------------------------------------------
    assign ram1Cyc_o = WBs_CYC_i & (reqBank == BankRam1);
    assign ram2Cyc_o = WBs_CYC_i & (reqBank == BankRam2);
    assign ram3Cyc_o = WBs_CYC_i & (reqBank == BankRam3);
    assign regCyc_o  = WBs_CYC_i & (reqBank == BankRegs);

    // New access, not an ACK cycle
    assign accStart = WBs_CYC_i & WBs_STB_i & ~WBs_ACK_o;

    always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
    begin
        if (WBs_RST_i)
            lastBank <= BankRam1;
        else if (accStart)
            lastBank <= reqBank;
    end

    //------------------------------------------------------------
    // Return path
    //------------------------------------------------------------
    always_comb
    begin
        case (lastBank)
            BankRam1: WBs_DAT_o = ram1Dat_i;
            BankRam2: WBs_DAT_o = ram2Dat_i;
            BankRam3: WBs_DAT_o = ram3Dat_i;
            default:  WBs_DAT_o = regDat_i;
        endcase
    end

    assign WBs_ACK_o = ramAck_i | regAck_i;

    // Only one target answers per access
    ackExclusive: assert property (
        @(posedge WBs_CLK_i) disable iff (WBs_RST_i) !(ramAck_i && regAck_i)
    ) else $error("RAM and register ACK together at %0t", $time);

endmodule

// File: hw/fpgaTop.sv
// ------------------------------------------------------------
// FPGA storage top level
// Decoder, RAM block and register bank on one client bus
// ------------------------------------------------------------
module fpgaTop import fpgaRamPkg::*; #(
    parameter logic [31:0] IdValue     = 32'h0F9A_0001,
    parameter logic [31:0] DefRegValue = 32'hFABD_EFAC
) (
    input  logic                 WBs_CLK_i,
    input  logic                 WBs_RST_i,
    input  logic [AddrWidth-1:0] WBs_ADR_i,      // Word address
    input  logic [DataWidth-1:0] WBs_DAT_i,
    input  logic [3:0]           WBs_BYTE_STB_i,
    input  logic                 WBs_WE_i,
    input  logic                 WBs_STB_i,
    input  logic                 WBs_CYC_i,
    output logic [DataWidth-1:0] WBs_DAT_o,
    output logic                 WBs_ACK_o
);

    wbReq_t               req;
    logic                 ram1Cyc;
    logic                 ram2Cyc;
    logic                 ram3Cyc;
    logic                 regCyc;
    logic [DataWidth-1:0] ram1Dat;
    logic [DataWidth-1:0] ram2Dat;
    logic [DataWidth-1:0] ram3Dat;
    logic [DataWidth-1:0] regDat;
    logic                 ramAck;
    logic                 regAck;
    logic                 ramWrDone;

    // Request fields in one bundle
    assign req = {WBs_ADR_i, WBs_DAT_i, WBs_BYTE_STB_i, WBs_WE_i};

    wbBusDecode decode (
        .WBs_CLK_i (WBs_CLK_i),  .WBs_RST_i (WBs_RST_i),
        .req_i     (req),
        .WBs_CYC_i (WBs_CYC_i),  .WBs_STB_i (WBs_STB_i),
        .ram1Cyc_o (ram1Cyc),    .ram2Cyc_o (ram2Cyc),
        .ram3Cyc_o (ram3Cyc),    .regCyc_o  (regCyc),
        .ram1Dat_i (ram1Dat),    .ram2Dat_i (ram2Dat),
        .ram3Dat_i (ram3Dat),    .regDat_i  (regDat),
        .ramAck_i  (ramAck),     .regAck_i  (regAck),
        .WBs_DAT_o (WBs_DAT_o),  .WBs_ACK_o (WBs_ACK_o)
    );

    fpgaRams rams (
        .WBs_CLK_i (WBs_CLK_i),  .WBs_RST_i   (WBs_RST_i),
        .req_i     (req),        .WBs_STB_i   (WBs_STB_i),
        .ram1Cyc_i (ram1Cyc),    .ram2Cyc_i   (ram2Cyc),
        .ram3Cyc_i (ram3Cyc),
        .ram1Dat_o (ram1Dat),    .ram2Dat_o   (ram2Dat),
        .ram3Dat_o (ram3Dat),
        .ramAck_o  (ramAck),     .ramWrDone_o (ramWrDone)
    );

    fpgaRegs #(.IdValue(IdValue), .DefRegValue(DefRegValue)) regs (
        .WBs_CLK_i   (WBs_CLK_i),  .WBs_RST_i (WBs_RST_i),
        .req_i       (req),        .WBs_STB_i (WBs_STB_i),
        .regCyc_i    (regCyc),     .ramWrDone_i (ramWrDone),
        .regDat_o    (regDat),     .regAck_o  (regAck)
    );

endmodule

// File: bench/fpgaTop_tb.sv
// ------------------------------------------------------------
// FPGA storage testbench
// Bus traffic against shadow memories, checked by assertions
// ------------------------------------------------------------
module fpgaTop_tb import fpgaRamPkg::*; ();

    localparam logic [31:0] TbIdValue  = 32'h5A17_0C3E;
    localparam logic [31:0] TbDefValue = 32'hC0DE_7A55;
    localparam int          AckTimeout = 20;     // Cycles allowed for one ACK
    localparam int          RandOps    = 800;

    logic        WBs_CLK_i;
    logic        WBs_RST_i;
    logic [11:0] WBs_ADR_i;
    logic [31:0] WBs_DAT_i;
    logic [3:0]  WBs_BYTE_STB_i;
    logic        WBs_WE_i;
    logic        WBs_STB_i;
    logic        WBs_CYC_i;
    logic [31:0] WBs_DAT_o;
    logic        WBs_ACK_o;

    // Shadow copies of the storage
    logic [15:0] ram1Model [512];
    logic [7:0]  ram2Model [1024];
    logic [31:0] ram3Model [512];
    logic [31:0] scratchModel;
    logic [31:0] wrCntModel;                     // RAM writes since reset

    logic        chkRead;                        // Read in flight
    logic [31:0] expDat;
    logic        timedOut;
    int          dataErrs;
    int          ackErrs;
    int          timeoutErrs;

    fpgaTop #(.IdValue(TbIdValue), .DefRegValue(TbDefValue)) DUT (
        .WBs_CLK_i      (WBs_CLK_i),
        .WBs_RST_i      (WBs_RST_i),
        .WBs_ADR_i      (WBs_ADR_i),
        .WBs_DAT_i      (WBs_DAT_i),
        .WBs_BYTE_STB_i (WBs_BYTE_STB_i),
        .WBs_WE_i       (WBs_WE_i),
        .WBs_STB_i      (WBs_STB_i),
        .WBs_CYC_i      (WBs_CYC_i),
        .WBs_DAT_o      (WBs_DAT_o),
        .WBs_ACK_o      (WBs_ACK_o)
    );

    initial
    begin
        WBs_CLK_i = 1'b0;
        forever #2 WBs_CLK_i = ~WBs_CLK_i;       // Period 4
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    readDataMatch: assert property (
        @(posedge WBs_CLK_i) disable iff (WBs_RST_i)
            (WBs_ACK_o && chkRead) |-> (WBs_DAT_o == expDat)
    ) else begin
        dataErrs++;
        $display("FAIL %0t: read data %h, expected %h", $time, $sampled(WBs_DAT_o), expDat);
    end

    // Access start gives ACK in the next cycle
    ackNextCycle: assert property (
        @(posedge WBs_CLK_i) disable iff (WBs_RST_i)
            (WBs_CYC_i && WBs_STB_i && !WBs_ACK_o) |=> WBs_ACK_o
    ) else begin
        ackErrs++;
        $display("FAIL %0t: no ACK one cycle after access start", $time);
    end

    ackOnePulse: assert property (
        @(posedge WBs_CLK_i) disable iff (WBs_RST_i) WBs_ACK_o |=> !WBs_ACK_o
    ) else begin
        ackErrs++;
        $display("FAIL %0t: ACK longer than one cycle", $time);
    end

    ackNeedsStb: assert property (
        @(posedge WBs_CLK_i) disable iff (WBs_RST_i) !WBs_STB_i |=> !WBs_ACK_o
    ) else begin
        ackErrs++;
        $display("FAIL %0t: ACK without a strobe", $time);
    end

    // ------------------------------------------------------------
    // Bus tasks
    // ------------------------------------------------------------
    // One access, held until ACK, then one idle cycle
    task automatic busCycle(input logic we, input logic [11:0] adr,
                            input logic [31:0] dat, input logic [3:0] stb);
        int   waitCnt;
        logic ackSeen;
        logic holdStb;                           // Keep STB over the ACK edge
        waitCnt = 0;
        ackSeen = 1'b0;
        holdStb = 1'($urandom);
        if (!timedOut)
        begin
            WBs_ADR_i      = adr;
            WBs_DAT_i      = dat;
            WBs_BYTE_STB_i = stb;
            WBs_WE_i       = we;
            WBs_CYC_i      = 1'b1;
            WBs_STB_i      = 1'b1;
            while (!ackSeen && waitCnt < AckTimeout)
            begin
                @(posedge WBs_CLK_i);
                #1;
                ackSeen = WBs_ACK_o;
                waitCnt++;
            end
            if (!holdStb || !ackSeen)
            begin
                WBs_CYC_i = 1'b0;
                WBs_STB_i = 1'b0;
                WBs_WE_i  = 1'b0;
            end
            if (!ackSeen)
            begin
                timeoutErrs++;
                timedOut = 1'b1;
                $display("Timeout: no ACK for the access to address %h", adr);
            end
            @(posedge WBs_CLK_i);                // ACK sample edge
            #1;
            if (WBs_STB_i)
            begin
                // Held strobe must not start a second access here
                WBs_CYC_i = 1'b0;
                WBs_STB_i = 1'b0;
                WBs_WE_i  = 1'b0;
                @(posedge WBs_CLK_i);
                #1;
            end
        end
        chkRead = 1'b0;
    endtask

    task automatic ramWrite(input bank_e bank, input logic [9:0] offset,
                            input logic [31:0] dat, input logic [3:0] stb);
        case (bank)
            BankRam1:
            begin
                for (int lane = 0; lane < 2; lane++)
                begin
                    if (stb[lane])
                        ram1Model[offset[8:0]][lane*8 +: 8] = dat[lane*8 +: 8];
                end
            end
            BankRam2:
            begin
                if (stb[0])
                    ram2Model[offset] = dat[7:0];  // Lane 0 only
            end
            default:
            begin
                for (int lane = 0; lane < 4; lane++)
                begin
                    if (stb[lane])
                        ram3Model[offset[8:0]][lane*8 +: 8] = dat[lane*8 +: 8];
                end
            end
        endcase
        wrCntModel = wrCntModel + 32'd1;          // Counts with or without lanes
        busCycle(1'b1, {bank, offset}, dat, stb);
    endtask

    task automatic ramRead(input bank_e bank, input logic [9:0] offset);
        case (bank)
            BankRam1: expDat = {16'h0000, ram1Model[offset[8:0]]};
            BankRam2: expDat = {24'h00_0000, ram2Model[offset]};
            default:  expDat = ram3Model[offset[8:0]];
        endcase
        chkRead = 1'b1;
        busCycle(1'b0, {bank, offset}, $urandom, 4'hF);
    endtask

    task automatic regWrite(input logic [1:0] idx, input logic [31:0] dat,
                            input logic [3:0] stb);
        if (idx == 2'd1)
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (stb[lane])
                    scratchModel[lane*8 +: 8] = dat[lane*8 +: 8];
            end
        end
        busCycle(1'b1, {BankRegs, 8'($urandom), idx}, dat, stb);  // Spare bits random
    endtask

    task automatic regRead(input logic [1:0] idx);
        case (idx)
            2'd0:    expDat = TbIdValue;
            2'd1:    expDat = scratchModel;
            2'd2:    expDat = wrCntModel;
            default: expDat = TbDefValue;
        endcase
        chkRead = 1'b1;
        busCycle(1'b0, {BankRegs, 8'($urandom), idx}, 32'h0, 4'hF);
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial
    begin
        bank_e      bank;
        logic [9:0] offset;
        int         op;
        void'($urandom(41994));
        WBs_RST_i      = 1'b1;
        WBs_ADR_i      = '0;
        WBs_DAT_i      = '0;
        WBs_BYTE_STB_i = '0;
        WBs_WE_i       = 1'b0;
        WBs_STB_i      = 1'b0;
        WBs_CYC_i      = 1'b0;
        chkRead        = 1'b0;
        expDat         = '0;
        timedOut       = 1'b0;
        scratchModel   = '0;
        wrCntModel     = '0;
        dataErrs       = 0;
        ackErrs        = 0;
        timeoutErrs    = 0;
        repeat (16) @(posedge WBs_CLK_i);
        #1;
        WBs_RST_i = 1'b0;
        ackLowAfterReset: assert (!WBs_ACK_o)
            else begin
                ackErrs++;
                $display("FAIL %0t: ACK high after reset", $time);
            end
        @(posedge WBs_CLK_i);
        #1;

        // Register bank straight out of reset
        regRead(RegScratchIdx);
        regRead(RegWrCntIdx);
        regRead(RegIdIdx);
        regRead(2'd3);

        // Every RAM row gets known contents
        for (int i = 0; i < 512; i++)
            ramWrite(BankRam1, 10'(i), $urandom, 4'hF);
        for (int i = 0; i < 1024; i++)
            ramWrite(BankRam2, 10'(i), $urandom, 4'hF);
        for (int i = 0; i < 512; i++)
            ramWrite(BankRam3, 10'(i), $urandom, 4'hF);
        regRead(RegWrCntIdx);

        // Partial lanes and offset wrap
        ramWrite(BankRam3, 10'd5, 32'hA1B2_C3D4, 4'b0101);
        ramRead(BankRam3, 10'd5);
        ramWrite(BankRam1, 10'd7, 32'h0000_5E6F, 4'b0010);
        ramRead(BankRam1, 10'd519);               // Same row as 7
        ramWrite(BankRam2, 10'd900, 32'h0000_00FF, 4'b1110);
        ramRead(BankRam2, 10'd900);

        // Scratch lanes, read-only indexes
        regWrite(RegScratchIdx, 32'hDEAD_BEEF, 4'hF);
        regRead(RegScratchIdx);
        regWrite(RegScratchIdx, 32'h1234_5678, 4'b1001);
        regRead(RegScratchIdx);
        regWrite(RegIdIdx, 32'hFFFF_FFFF, 4'hF);
        regWrite(RegWrCntIdx, 32'h0000_0000, 4'hF);
        regWrite(2'd3, 32'h0BAD_F00D, 4'hF);
        regRead(RegIdIdx);
        regRead(RegWrCntIdx);
        regRead(2'd3);

        // Random mix of all targets
        for (int n = 0; n < RandOps; n++)
        begin
            op     = int'($urandom_range(7, 0));
            bank   = bank_e'(2'($urandom_range(2, 0)));
            offset = 10'($urandom);
            case (op)
                0, 1, 2: ramWrite(bank, offset, $urandom, 4'($urandom));
                3, 4, 5: ramRead(bank, offset);
                6:       regWrite(2'($urandom), $urandom, 4'($urandom));
                default: regRead(2'($urandom));
            endcase
        end
        regRead(RegWrCntIdx);

        $display("Errors: data %0d, ack %0d, timeout %0d", dataErrs, ackErrs, timeoutErrs);
        if (dataErrs == 0 && ackErrs == 0 && timeoutErrs == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: sources.f
hw/fpgaRamPkg.sv
hw/syncRam.sv
hw/fpgaRams.sv
hw/fpgaRegs.sv
hw/wbBusDecode.sv
hw/fpgaTop.sv
bench/fpgaTop_tb.sv

// File: Makefile
# Verilator build and run of the FPGA storage testbench

TOP := fpgaTop_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)

# Result decided from the log
run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then \
		echo "Run failed"; exit 1; \
	fi
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
